// File: robot_motion_pkg.sv
package robot_motion_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Maneuvers requested by the planner
	////////////////////////////////////////////////////////////////////////////

	// Whole-robot movement, consumed by the drive encoder
	typedef enum logic [3:0] {
		NEUTRAL       = 4'd0,
		FORWARD       = 4'd1,
		REVERSE       = 4'd2,
		FORWARD_RIGHT = 4'd3,
		BACK_RIGHT    = 4'd4,
		FORWARD_LEFT  = 4'd5,
		BACK_LEFT     = 4'd6,
		SPIN_RIGHT    = 4'd7,
		SPIN_LEFT     = 4'd8
	} maneuver_t;

	////////////////////////////////////////////////////////////////////////////
	// Motor control word fields
	////////////////////////////////////////////////////////////////////////////

	// Direction field, bits 1:0 of a motor word
	typedef enum logic [1:0] {
		DIR_FORWARD = 2'd0,
		DIR_NEUTRAL = 2'd1,
		DIR_REVERSE = 2'd2
	} motor_dir_t;

	// Power field, bits 4:2 of a motor word
	// Duty cycle noted per level
	typedef enum logic [2:0] {
		PWR_13 = 3'd0,
		PWR_17 = 3'd1,
		PWR_25 = 3'd2,
		PWR_38 = 3'd3,
		PWR_50 = 3'd4,
		PWR_62 = 3'd5
	} power_t;

endpackage

// File: robot_nav_pkg.sv
package robot_nav_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Navigation commands and wall-following states
	////////////////////////////////////////////////////////////////////////////

	// Command codes from the route sequencer
	typedef enum logic [4:0] {
		NO_COMMAND = 5'h00,
		TURN_LEFT  = 5'h06,
		TURN_RIGHT = 5'h0C,
		STRAIGHT   = 5'h0E
	} command_t;

	// Side readings vs. the path distance, front reading named first
	typedef enum logic [2:0] {
		UNDETERMINED   = 3'd0,
		BOTH_EQUAL     = 3'd1,
		BOTH_LESS      = 3'd2,
		BOTH_GREATER   = 3'd3,
		F_LESS_B_GE    = 3'd4,
		F_GREATER_B_LE = 3'd5,
		F_EQUAL_B_NE   = 3'd6,
		GOAL           = 3'd7
	} wall_state_t;

	// Relation of one value to a reference
	typedef enum logic [1:0] {
		REL_LESS    = 2'd0,
		REL_EQUAL   = 2'd1,
		REL_GREATER = 2'd2
	} rel_t;

	// Default distance width and limits
	localparam int DIST_W_DEFAULT        = 8;
	localparam int CONTACT_LIMIT_DEFAULT = 3;
	localparam int GAP_LIMIT_DEFAULT     = 2;
	localparam int TURN_MARGIN_DEFAULT   = 10;

	// Range sensor reading at default width
	typedef logic [DIST_W_DEFAULT-1:0] dist_t;

endpackage

// File: range_flags_if.sv
`timescale 1ns/100ps

// Registered comparison results, classifier to planner
interface range_flags_if
	import robot_nav_pkg::*;
();
	// One pulse per classified reading set
	logic flags_valid;
	logic goal_hit;
	logic any_contact;
	logic back_contact;
	// Side readings vs. path
	rel_t front_rel;
	rel_t back_rel;
	// Side gap, direction and size
	logic gap_sign;
	rel_t gap_rel;
	logic turn_done;

	modport producer (
		output flags_valid, goal_hit, any_contact, back_contact,
		output front_rel, back_rel, gap_sign, gap_rel, turn_done
	);

	modport consumer (
		input flags_valid, goal_hit, any_contact, back_contact,
		input front_rel, back_rel, gap_sign, gap_rel, turn_done
	);
endinterface

// File: range_classifier.sv
`timescale 1ns/100ps

module range_classifier
	import robot_nav_pkg::*;
#(
	parameter int DIST_W        = DIST_W_DEFAULT,
	parameter int CONTACT_LIMIT = CONTACT_LIMIT_DEFAULT,
	parameter int GAP_LIMIT     = GAP_LIMIT_DEFAULT,
	parameter int TURN_MARGIN   = TURN_MARGIN_DEFAULT
) (
	input  logic              CLK,
	input  logic              rst,
	input  logic              meas_valid,
	input  logic [DIST_W-1:0] dist_front,
	input  logic [DIST_W-1:0] dist_side_front,
	input  logic [DIST_W-1:0] dist_side_back,
	input  logic [DIST_W-1:0] path,
	input  logic [DIST_W-1:0] dist_check,
	input  logic [1:0]        angle_dir,
	range_flags_if.producer   flags
);
	// Limits at reading width
	localparam logic [DIST_W-1:0] CONTACT_D = DIST_W'(CONTACT_LIMIT);
	localparam logic [DIST_W-1:0] GAP_D     = DIST_W'(GAP_LIMIT);
	localparam logic [DIST_W-1:0] MARGIN_D  = DIST_W'(TURN_MARGIN);

	logic              back_wider;
	logic [DIST_W-1:0] side_gap;
	logic [DIST_W-1:0] check_lead;

	// Three-way compare of a against b
	function automatic rel_t rel_of(input logic [DIST_W-1:0] a, input logic [DIST_W-1:0] b);
		if (a < b)
			return REL_LESS;
		else if (a == b)
			return REL_EQUAL;
		else
			return REL_GREATER;
	endfunction

	// Absolute side difference with the sign kept separately
	assign back_wider = dist_side_back > dist_side_front;
	assign side_gap   = back_wider ? dist_side_back - dist_side_front
	                               : dist_side_front - dist_side_back;

	// Wraps when front is beyond the check point
	assign check_lead = dist_check - dist_front;

	////////////////////////////////////////////////////////////////////////////
	// Strobe delay
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst)
			flags.flags_valid <= 1'b0;
		else
			flags.flags_valid <= meas_valid;
	end

	////////////////////////////////////////////////////////////////////////////
	// Comparison registers loaded only on a new reading set
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (meas_valid) begin
			flags.goal_hit     <= dist_front <= dist_check;
			// Any sensor closer than the contact limit
			flags.any_contact  <= (dist_front < CONTACT_D) || (dist_side_front < CONTACT_D) ||
			                      (dist_side_back < CONTACT_D);
			flags.back_contact <= dist_side_back < CONTACT_D;
			flags.front_rel    <= rel_of(dist_side_front, path);
			flags.back_rel     <= rel_of(dist_side_back, path);
			flags.gap_sign     <= back_wider;
			flags.gap_rel      <= rel_of(side_gap, GAP_D);
			// Turn ends near the check point or once heading is reached
			flags.turn_done    <= (check_lead <= MARGIN_D) || (angle_dir == 2'd0);
		end
	end

endmodule

// File: maneuver_planner.sv
`timescale 1ns/100ps

module maneuver_planner
	import robot_motion_pkg::*;
	import robot_nav_pkg::*;
(
	input  logic            CLK,
	input  logic            rst,
	range_flags_if.consumer flags,
	input  logic            sw_manual,
	input  logic [4:0]      btn,
	input  command_t        command,
	input  logic            run_flag,
	output maneuver_t       maneuver,
	output logic            next_flag,
	output wall_state_t     wall_state
);
	maneuver_t   manual_mnv;
	wall_state_t entry_state;
	logic        state_holds;
	maneuver_t   steer_mnv;
	maneuver_t   contact_mnv;

	////////////////////////////////////////////////////////////////////////////
	// Manual drive from one-hot buttons
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (btn)
			5'd1:    manual_mnv = FORWARD_RIGHT;
			5'd2:    manual_mnv = REVERSE;
			5'd4:    manual_mnv = FORWARD;
			5'd8:    manual_mnv = FORWARD_LEFT;
			5'd16:   manual_mnv = SPIN_RIGHT;
			// No button or several at once
			default: manual_mnv = NEUTRAL;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Wall-following decode
	////////////////////////////////////////////////////////////////////////////

	// State picked from UNDETERMINED, first match wins
	always_comb begin
		if (flags.front_rel == REL_EQUAL && flags.back_rel == REL_EQUAL)
			entry_state = BOTH_EQUAL;
		else if (flags.front_rel == REL_LESS && flags.back_rel == REL_LESS)
			entry_state = BOTH_LESS;
		else if (flags.front_rel == REL_GREATER && flags.back_rel == REL_GREATER)
			entry_state = BOTH_GREATER;
		else if (flags.front_rel == REL_LESS)
			entry_state = F_LESS_B_GE;
		else if (flags.front_rel == REL_GREATER)
			entry_state = F_GREATER_B_LE;
		else if (flags.back_rel == REL_LESS)
			entry_state = F_EQUAL_B_NE;
		else
			// Front equal, back greater stays unresolved
			entry_state = UNDETERMINED;
	end

	// Defining relation of the current state and its steering
	always_comb begin
		state_holds = 1'b0;
		steer_mnv   = NEUTRAL;
		case (wall_state)
			BOTH_EQUAL: begin
				state_holds = flags.front_rel == REL_EQUAL && flags.back_rel == REL_EQUAL;
				steer_mnv   = FORWARD;
			end
			F_LESS_B_GE: begin
				state_holds = flags.front_rel == REL_LESS && flags.back_rel != REL_LESS;
				steer_mnv   = BACK_RIGHT;
			end
			F_GREATER_B_LE: begin
				state_holds = flags.front_rel == REL_GREATER && flags.back_rel != REL_GREATER;
				steer_mnv   = FORWARD_LEFT;
			end
			F_EQUAL_B_NE: begin
				state_holds = flags.front_rel == REL_EQUAL && flags.back_rel != REL_EQUAL;
				steer_mnv   = FORWARD;
			end
			BOTH_GREATER: begin
				state_holds = flags.front_rel == REL_GREATER && flags.back_rel == REL_GREATER;
				// Back further out than front, pull the tail in
				if (flags.gap_sign && flags.gap_rel == REL_GREATER)
					steer_mnv = BACK_RIGHT;
				else if (flags.gap_sign && flags.gap_rel == REL_EQUAL)
					steer_mnv = FORWARD;
				else
					steer_mnv = FORWARD_LEFT;
			end
			BOTH_LESS: begin
				state_holds = flags.front_rel == REL_LESS && flags.back_rel == REL_LESS;
				// Mirror case, front further out than back
				if (!flags.gap_sign && flags.gap_rel == REL_GREATER)
					steer_mnv = FORWARD_LEFT;
				else if (!flags.gap_sign && flags.gap_rel == REL_EQUAL)
					steer_mnv = FORWARD;
				else
					steer_mnv = FORWARD_RIGHT;
			end
			default: begin
				// UNDETERMINED and GOAL handled in the FSM
				state_holds = 1'b0;
			end
		endcase
	end

	// Back away from contact, push forward if the tail is touching
	assign contact_mnv = ((wall_state == BOTH_GREATER || wall_state == F_GREATER_B_LE) &&
	                      flags.back_contact) ? FORWARD : BACK_RIGHT;

	////////////////////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			maneuver   <= NEUTRAL;
			wall_state <= UNDETERMINED;
			next_flag  <= 1'b0;
		end else if (sw_manual) begin
			// Buttons every cycle, wall state kept
			maneuver <= manual_mnv;
		end else if (flags.flags_valid) begin
			case (command)
				STRAIGHT: begin
					if (!run_flag) begin
						maneuver <= NEUTRAL;
					end else if (flags.goal_hit) begin
						// Goal overrides everything
						maneuver   <= NEUTRAL;
						wall_state <= GOAL;
						next_flag  <= 1'b1;
					end else begin
						next_flag <= 1'b0;
						case (wall_state)
							UNDETERMINED: begin
								maneuver   <= NEUTRAL;
								wall_state <= entry_state;
							end
							GOAL: begin
								// Flag stays up for the sequencer
								maneuver   <= NEUTRAL;
								wall_state <= UNDETERMINED;
								next_flag  <= 1'b1;
							end
							default: begin
								if (flags.any_contact) begin
									maneuver <= contact_mnv;
								end else if (state_holds) begin
									maneuver <= steer_mnv;
								end else begin
									maneuver   <= NEUTRAL;
									wall_state <= UNDETERMINED;
								end
							end
						endcase
					end
				end
				TURN_RIGHT: begin
					next_flag <= 1'b0;
					if (!run_flag) begin
						maneuver <= NEUTRAL;
					end else if (flags.turn_done) begin
						maneuver  <= NEUTRAL;
						next_flag <= 1'b1;
					end else begin
						maneuver <= SPIN_RIGHT;
					end
				end
				NO_COMMAND: begin
					maneuver <= NEUTRAL;
				end
				default: begin
					// TURN_LEFT and unknown codes leave everything as is
					maneuver <= maneuver;
				end
			endcase
		end
	end

endmodule

// File: motor_drive_encoder.sv
`timescale 1ns/100ps

module motor_drive_encoder
	import robot_motion_pkg::*;
(
	input  logic       CLK,
	input  logic       rst,
	input  maneuver_t  maneuver,
	input  logic [7:0] sw,
	output logic [4:0] mc1,
	output logic [4:0] mc2
);
	// mc1 drives the right motor, mc2 the left
	motor_dir_t dir_right;
	motor_dir_t dir_left;
	power_t     power;

	////////////////////////////////////////////////////////////////////////////
	// Maneuver to per-motor direction
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (maneuver)
			FORWARD: begin
				dir_right = DIR_FORWARD;
				dir_left  = DIR_FORWARD;
			end
			REVERSE: begin
				dir_right = DIR_REVERSE;
				dir_left  = DIR_REVERSE;
			end
			FORWARD_RIGHT: begin
				dir_right = DIR_NEUTRAL;
				dir_left  = DIR_FORWARD;
			end
			BACK_RIGHT: begin
				dir_right = DIR_REVERSE;
				dir_left  = DIR_NEUTRAL;
			end
			FORWARD_LEFT: begin
				dir_right = DIR_FORWARD;
				dir_left  = DIR_NEUTRAL;
			end
			BACK_LEFT: begin
				dir_right = DIR_NEUTRAL;
				dir_left  = DIR_REVERSE;
			end
			// Spins turn the wheels against each other
			SPIN_RIGHT: begin
				dir_right = DIR_REVERSE;
				dir_left  = DIR_FORWARD;
			end
			SPIN_LEFT: begin
				dir_right = DIR_FORWARD;
				dir_left  = DIR_REVERSE;
			end
			default: begin
				dir_right = DIR_NEUTRAL;
				dir_left  = DIR_NEUTRAL;
			end
		endcase
	end

	// Switch power levels 1 to 5, lowest level for anything else
	always_comb begin
		if (sw >= 8'd1 && sw <= 8'd5)
			power = power_t'(sw[2:0]);
		else
			power = PWR_13;
	end

	// Same power on both sides
	always_ff @(posedge CLK) begin
		if (rst) begin
			mc1 <= {PWR_13, DIR_NEUTRAL};
			mc2 <= {PWR_13, DIR_NEUTRAL};
		end else begin
			mc1 <= {power, dir_right};
			mc2 <= {power, dir_left};
		end
	end

endmodule

// File: direction_control.sv
`timescale 1ns/100ps

module direction_control
	import robot_motion_pkg::*;
	import robot_nav_pkg::*;
#(
	parameter int DIST_W        = $bits(dist_t),
	parameter int CONTACT_LIMIT = CONTACT_LIMIT_DEFAULT,
	parameter int GAP_LIMIT     = GAP_LIMIT_DEFAULT,
	parameter int TURN_MARGIN   = TURN_MARGIN_DEFAULT
) (
	input  logic              CLK,
	input  logic              rst,
	input  logic [7:0]        sw,
	input  logic [4:0]        btn,
	input  logic [DIST_W-1:0] dist_front,
	input  logic [DIST_W-1:0] dist_side_front,
	input  logic [DIST_W-1:0] dist_side_back,
	input  logic [DIST_W-1:0] path,
	input  logic [DIST_W-1:0] dist_check,
	input  logic [1:0]        angle_dir,
	input  logic [4:0]        command,
	input  logic              run_flag,
	input  logic              meas_valid,
	output logic [4:0]        mc1,
	output logic [4:0]        mc2,
	output logic              next_flag,
	output logic [7:0]        led
);
	maneuver_t   maneuver;
	wall_state_t wall_state;

	range_flags_if flags_bus ();

	// Stage 1, reading compare
	range_classifier #(
		.DIST_W       (DIST_W),
		.CONTACT_LIMIT(CONTACT_LIMIT),
		.GAP_LIMIT    (GAP_LIMIT),
		.TURN_MARGIN  (TURN_MARGIN)
	) i_classifier (
		.CLK            (CLK),
		.rst            (rst),
		.meas_valid     (meas_valid),
		.dist_front     (dist_front),
		.dist_side_front(dist_side_front),
		.dist_side_back (dist_side_back),
		.path           (path),
		.dist_check     (dist_check),
		.angle_dir      (angle_dir),
		.flags          (flags_bus.producer)
	);

	// Stage 2, command and wall-following FSM
	maneuver_planner i_planner (
		.CLK       (CLK),
		.rst       (rst),
		.flags     (flags_bus.consumer),
		.sw_manual (sw[7]),
		.btn       (btn),
		.command   (command_t'(command)),
		.run_flag  (run_flag),
		.maneuver  (maneuver),
		.next_flag (next_flag),
		.wall_state(wall_state)
	);

	// Stage 3, motor words
	motor_drive_encoder i_encoder (
		.CLK     (CLK),
		.rst     (rst),
		.maneuver(maneuver),
		.sw      (sw),
		.mc1     (mc1),
		.mc2     (mc2)
	);

	// Wall state on the low LEDs
	assign led = {5'b00000, wall_state};

endmodule

// File: tb_direction_control.sv
`timescale 1ns/100ps

module tb_direction_control
	import robot_motion_pkg::*;
	import robot_nav_pkg::*;
();
	logic       CLK;
	logic       rst;
	logic [7:0] sw;
	logic [4:0] btn;
	logic [7:0] dist_front;
	logic [7:0] dist_side_front;
	logic [7:0] dist_side_back;
	logic [7:0] path;
	logic [7:0] dist_check;
	logic [1:0] angle_dir;
	logic [4:0] command;
	logic       run_flag;
	logic       meas_valid;
	logic [4:0] mc1;
	logic [4:0] mc2;
	logic       next_flag;
	logic [7:0] led;
	logic [31:0] lfsr;

	direction_control i_dut (
		.CLK(CLK), .rst(rst), .sw(sw), .btn(btn),
		.dist_front(dist_front), .dist_side_front(dist_side_front),
		.dist_side_back(dist_side_back), .path(path), .dist_check(dist_check),
		.angle_dir(angle_dir), .command(command), .run_flag(run_flag),
		.meas_valid(meas_valid), .mc1(mc1), .mc2(mc2), .next_flag(next_flag), .led(led)
	);

	// 20 ns clock
	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	// Hard stop if the sequence stalls
	initial begin
		#200000;
		$display("Simulation ran past its time limit");
		$display("TEST FAIL");
		$fatal(1, "watchdog");
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// n random bits with one step per bit
	task automatic draw(input int n, output logic [7:0] v);
		v = 8'h00;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// Expected motor word from power and direction
	function automatic logic [4:0] motor_word(input logic [2:0] pw, input motor_dir_t d);
		return {pw, d};
	endfunction

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value check");
		end
	endtask

	task automatic check_motors(input logic [4:0] e1, input logic [4:0] e2);
		check_val("mc1", {3'b000, mc1}, {3'b000, e1});
		check_val("mc2", {3'b000, mc2}, {3'b000, e2});
	endtask

	task automatic give_up(input string what);
		$display("Timed out waiting for %s", what);
		$display("TEST FAIL");
		$fatal(1, "wait timeout");
	endtask

	// n rising edges and then the stable falling edge
	task automatic after_edges(input int n);
		repeat (n) @(posedge CLK);
		@(negedge CLK);
	endtask

	// One-cycle strobe that returns on the edge the DUT samples it
	task automatic send_reading();
		@(posedge CLK);
		meas_valid <= 1'b1;
		@(posedge CLK);
		meas_valid <= 1'b0;
	endtask

	// Front beyond the check point and contact limit with sides on the path
	task automatic follow_readings();
		logic [7:0] r;
		logic [7:0] chk;
		draw(5, r);
		path            <= 8'd20 + r;
		dist_side_front <= 8'd20 + r;
		dist_side_back  <= 8'd20 + r;
		draw(6, chk);
		draw(6, r);
		dist_check <= chk;
		dist_front <= chk + 8'd4 + r;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [4:0] btn_vals [5] = '{5'd1, 5'd2, 5'd4, 5'd8, 5'd16};
		motor_dir_t exp_r [5] = '{DIR_NEUTRAL, DIR_REVERSE, DIR_FORWARD, DIR_FORWARD, DIR_REVERSE};
		motor_dir_t exp_l [5] = '{DIR_FORWARD, DIR_REVERSE, DIR_FORWARD, DIR_NEUTRAL, DIR_FORWARD};
		logic [7:0] r;
		logic [7:0] chk;
		logic [2:0] pw;
		int n;
		lfsr = 32'hfc2099ab;
		rst <= 1'b1;
		sw <= 8'h00;
		btn <= 5'd0;
		dist_front <= 8'd0;
		dist_side_front <= 8'd0;
		dist_side_back <= 8'd0;
		path <= 8'd0;
		dist_check <= 8'd0;
		angle_dir <= 2'd1;
		command <= NO_COMMAND;
		run_flag <= 1'b0;
		meas_valid <= 1'b0;

		// Reset held 4 cycles and checked one after
		for (int i = 0; i < 4; i++) begin
			@(posedge CLK);
			if (i == 3)
				rst <= 1'b0;
			@(negedge CLK);
			check_motors(motor_word(3'd0, DIR_NEUTRAL), motor_word(3'd0, DIR_NEUTRAL));
			check_val("next_flag", {7'd0, next_flag}, 8'd0);
			check_val("led", led, 8'd0);
		end
		after_edges(1);
		check_motors(motor_word(3'd0, DIR_NEUTRAL), motor_word(3'd0, DIR_NEUTRAL));
		check_val("next_flag", {7'd0, next_flag}, 8'd0);
		check_val("led", led, 8'd0);

		// Manual buttons with sw at 0x80 for power 0
		@(posedge CLK);
		sw <= 8'h80;
		for (int i = 0; i < 5; i++) begin
			btn <= btn_vals[i];
			after_edges(2);
			check_motors(motor_word(3'd0, exp_r[i]), motor_word(3'd0, exp_l[i]));
			@(posedge CLK);
		end
		btn <= 5'd0;
		after_edges(2);
		check_motors(motor_word(3'd0, DIR_NEUTRAL), motor_word(3'd0, DIR_NEUTRAL));

		// Power levels while the maneuver holds NEUTRAL between strobes
		for (int k = 0; k < 9; k++) begin
			@(posedge CLK);
			sw <= (k == 8) ? 8'h85 : 8'(k);
			pw = (k >= 1 && k <= 5) ? 3'(k) : 3'd0;
			after_edges(1);
			check_motors(motor_word(pw, DIR_NEUTRAL), motor_word(pw, DIR_NEUTRAL));
		end

		// STRAIGHT goal with front at or below check
		@(posedge CLK);
		sw <= 8'h00;
		command <= STRAIGHT;
		run_flag <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			@(posedge CLK);
			draw(8, chk);
			draw(8, r);
			dist_check <= chk;
			dist_front <= chk & r;
			draw(8, r);
			dist_side_front <= r;
			draw(8, r);
			dist_side_back <= r;
			send_reading();
			after_edges(1);
			check_val("next_flag", {7'd0, next_flag}, 8'd1);
			check_val("led", led, {5'd0, GOAL});
			after_edges(1);
			check_motors(motor_word(3'd0, DIR_NEUTRAL), motor_word(3'd0, DIR_NEUTRAL));
		end

		// STRAIGHT follow strobed until BOTH_EQUAL
		n = 0;
		do begin
			@(posedge CLK);
			follow_readings();
			send_reading();
			after_edges(1);
			n++;
			if (n > 4 && led != {5'd0, BOTH_EQUAL})
				give_up("wall state BOTH_EQUAL");
		end while (led != {5'd0, BOTH_EQUAL});
		@(posedge CLK);
		follow_readings();
		send_reading();
		after_edges(2);
		check_motors(motor_word(3'd0, DIR_FORWARD), motor_word(3'd0, DIR_FORWARD));

		// TURN_RIGHT far from the check point with heading not reached
		@(posedge CLK);
		command <= TURN_RIGHT;
		angle_dir <= 2'd2;
		follow_readings();
		send_reading();
		after_edges(2);
		check_motors(motor_word(3'd0, DIR_REVERSE), motor_word(3'd0, DIR_FORWARD));
		check_val("next_flag", {7'd0, next_flag}, 8'd0);

		// Heading reached
		@(posedge CLK);
		angle_dir <= 2'd0;
		send_reading();
		n = 0;
		do begin
			after_edges(1);
			n++;
			if (n > 6 && next_flag !== 1'b1)
				give_up("next_flag after turn");
		end while (next_flag !== 1'b1);
		after_edges(1);
		check_motors(motor_word(3'd0, DIR_NEUTRAL), motor_word(3'd0, DIR_NEUTRAL));

		// run_flag low stops the turn
		@(posedge CLK);
		angle_dir <= 2'd3;
		run_flag <= 1'b0;
		send_reading();
		after_edges(2);
		check_motors(motor_word(3'd0, DIR_NEUTRAL), motor_word(3'd0, DIR_NEUTRAL));
		check_val("next_flag", {7'd0, next_flag}, 8'd0);

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: compile.f
robot_motion_pkg.sv
robot_nav_pkg.sv
range_flags_if.sv
range_classifier.sv
maneuver_planner.sv
motor_drive_encoder.sv
direction_control.sv
tb_direction_control.sv

// File: run.sh
#!/bin/sh
# Build and run the direction controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_direction_control \
	-f compile.f

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/Vtb_direction_control
